//--- alu_core.f
+incdir+testbench
rtl/alu_pkg.sv
rtl/alu_ctrl_if.sv
rtl/alu_shifter.sv
rtl/alu_controller.sv
rtl/alu_exec.sv
rtl/alu_writeback.sv
rtl/alu_core.sv
testbench/tb_alu_core.sv

//--- testbench/tb_alu_model.svh
/* testbench reference model
   expected ALU result and flags, and the Galois LFSR behind the random stimulus */
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

// returns {result, z, v, c}
// compare passes prev_result through as its result
function automatic logic [DATA_W+2:0] alu_model(input logic [OP_W-1:0] op,
                                                input logic [DATA_W-1:0] a,
                                                input logic [DATA_W-1:0] b,
                                                input logic [DATA_W-1:0] prev_result);
  int unsigned       full;
  int                s;
  logic [DATA_W-1:0] value;
  logic [DATA_W-1:0] res;
  logic              v;
  logic              c;

  s     = b[SHAMT_W-1:0];
  full  = 0;
  value = '0;
  v     = 1'b0;
  c     = 1'b0;
  case (op)
    OP_ADD:
    begin
      full  = a + b;
      value = full[DATA_W-1:0];
      c     = (full >> DATA_W) != 0;
      v     = (a[DATA_W-1] == b[DATA_W-1]) && (value[DATA_W-1] != a[DATA_W-1]);
    end
    OP_SUB, OP_CMP:
    begin
      value = a - b;
      c     = a < b;
      v     = (a[DATA_W-1] != b[DATA_W-1]) && (value[DATA_W-1] != a[DATA_W-1]);
    end
    OP_INC_A:
    begin
      value = a + 1;
      c     = (a == 8'hff);
      v     = (a == 8'h7f);
    end
    OP_INC_B:
    begin
      value = b + 1;
      c     = (b == 8'hff);
      v     = (b == 8'h7f);
    end
    OP_DEC_A:
    begin
      value = a - 1;
      c     = (a == 8'h00);
      v     = (a == 8'h80);
    end
    OP_DEC_B:
    begin
      value = b - 1;
      c     = (b == 8'h00);
      v     = (b == 8'h80);
    end
    OP_MUL:
    begin
      full  = a * b;
      value = full[DATA_W-1:0];
      c     = full >= 256;
    end
    OP_AND:   value = a & b;
    OP_OR:    value = a | b;
    OP_XOR:   value = a ^ b;
    OP_CPL_A: value = ~a;
    OP_CPL_B: value = ~b;
    OP_ASL:
    begin
      value = a << s;
      c     = (s != 0) && a[DATA_W-s];
      v     = value[DATA_W-1] != a[DATA_W-1];
    end
    OP_ASR:
    begin
      value = $signed(a) >>> s;
      c     = (s != 0) && a[s-1];
    end
    default:
    begin
      // clear
      return '0;
    end
  endcase
  res = (op == OP_CMP) ? prev_result : value;
  return {res, value == '0, v, c};
endfunction

// one step of a right-shifting Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
  if (state[0])
    return (state >> 1) ^ 32'h8020_0003;
  else
    return state >> 1;
endfunction

`endif

//--- testbench/tb_alu_core.sv
/* alu core testbench
   directed table of operations, then a pipelined LFSR run checked against a model */
`timescale 1ns/1ps
`default_nettype none

module tb_alu_core
  import alu_pkg::*;
();

  localparam time CLK_PERIOD    = 100;
  localparam int  RESET_CYCLES  = 4;
  localparam int  N_VECTORS     = 20;
  localparam int  N_RANDOM      = 240;
  localparam int  FLUSH_TIMEOUT = 8;
  localparam int  MAX_CYCLES    = 2000;

  typedef struct packed {
    logic [OP_W-1:0]   op;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] result;
    logic              z;
    logic              v;
    logic              c;
  } vec_t;

  logic              clk;
  logic              reset;
  logic [OP_W-1:0]   opcode;
  logic [DATA_W-1:0] a;
  logic [DATA_W-1:0] b;
  logic [DATA_W-1:0] result;
  logic              flag_z;
  logic              flag_v;
  logic              flag_c;

  vec_t              vectors [N_VECTORS];
  vec_t              pending [$];
  int                n_vectors;
  logic [31:0]       lfsr_state;
  logic [DATA_W-1:0] model_result;
  int                n_checks;
  int                n_errors;

  alu_core i_dut (
    .clk    (clk),
    .reset  (reset),
    .opcode (opcode),
    .a      (a),
    .b      (b),
    .result (result),
    .flag_z (flag_z),
    .flag_v (flag_v),
    .flag_c (flag_c)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  task automatic add_vector(input logic [OP_W-1:0] op, input logic [DATA_W-1:0] a_in,
                            input logic [DATA_W-1:0] b_in, input logic [DATA_W-1:0] res,
                            input logic [2:0] zvc);
    vectors[n_vectors] = {op, a_in, b_in, res, zvc};
    n_vectors++;
  endtask

  task automatic load_vectors();
    add_vector(OP_ADD,   8'h7f, 8'h01, 8'h80, 3'b010);
    add_vector(OP_ADD,   8'hff, 8'h01, 8'h00, 3'b101);
    add_vector(OP_SUB,   8'h00, 8'h01, 8'hff, 3'b001);
    add_vector(OP_SUB,   8'h50, 8'hb0, 8'ha0, 3'b011);
    add_vector(OP_INC_A, 8'h41, 8'h00, 8'h42, 3'b000);
    add_vector(OP_INC_B, 8'h00, 8'hff, 8'h00, 3'b101);
    add_vector(OP_DEC_A, 8'h80, 8'h00, 8'h7f, 3'b010);
    add_vector(OP_DEC_B, 8'h00, 8'h00, 8'hff, 3'b001);
    add_vector(OP_MUL,   8'h10, 8'h10, 8'h00, 3'b101);
    add_vector(OP_MUL,   8'h0f, 8'h03, 8'h2d, 3'b000);
    // compare sets z but keeps the add's result
    add_vector(OP_ADD,   8'h12, 8'h34, 8'h46, 3'b000);
    add_vector(OP_CMP,   8'h55, 8'h55, 8'h46, 3'b100);
    add_vector(OP_AND,   8'hf0, 8'h3c, 8'h30, 3'b000);
    add_vector(OP_OR,    8'hf0, 8'h0f, 8'hff, 3'b000);
    add_vector(OP_XOR,   8'haa, 8'haa, 8'h00, 3'b100);
    add_vector(OP_CPL_A, 8'h0f, 8'h00, 8'hf0, 3'b000);
    add_vector(OP_CPL_B, 8'h00, 8'hff, 8'h00, 3'b100);
    add_vector(OP_ASR,   8'h80, 8'h03, 8'hf0, 3'b000);
    add_vector(OP_ASL,   8'h41, 8'h01, 8'h82, 3'b010);
    add_vector(OP_CLR,   8'h12, 8'h34, 8'h00, 3'b000);
  endtask

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
      bits       = {bits[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return bits;
  endfunction

  function automatic vec_t random_vector();
    vec_t vec;
    vec.op = OP_W'(rand_bits(OP_W));
    vec.a  = DATA_W'(rand_bits(DATA_W));
    vec.b  = DATA_W'(rand_bits(DATA_W));
    {vec.result, vec.z, vec.v, vec.c} = alu_model(vec.op, vec.a, vec.b, model_result);
    return vec;
  endfunction

  task automatic check_outputs(input vec_t exp);
    n_checks++;
    if (result !== exp.result)
    begin
      n_errors++;
      $display("[ERROR] %0t ns: op %0d a %02h b %02h, result %02h expected %02h",
               $time, exp.op, exp.a, exp.b, result, exp.result);
    end
    if ({flag_z, flag_v, flag_c} !== {exp.z, exp.v, exp.c})
    begin
      n_errors++;
      $display("[ERROR] %0t ns: op %0d a %02h b %02h, zvc %b%b%b expected %b%b%b",
               $time, exp.op, exp.a, exp.b, flag_z, flag_v, flag_c, exp.z, exp.v, exp.c);
    end
  endtask

  // the op driven two falling edges ago has just been written back
  task automatic apply_op(input vec_t vec);
    vec_t done;
    if (pending.size() >= 2)
    begin
      done = pending.pop_front();
      check_outputs(done);
    end
    opcode = vec.op;
    a      = vec.a;
    b      = vec.b;
    pending.push_back(vec);
    model_result = vec.result;
    @(negedge clk);
  endtask

  initial
  begin : main
    int   i;
    int   waited;
    vec_t done;
    clk          = 1'b0;
    reset        = 1'b1;
    opcode       = OP_CLR;
    a            = '0;
    b            = '0;
    n_vectors    = 0;
    lfsr_state   = 32'h15e2_2355;
    model_result = '0;
    n_checks     = 0;
    n_errors     = 0;
    load_vectors();
    for (i = 0; i < RESET_CYCLES; i++)
      @(negedge clk);
    reset = 1'b0;
    // nothing issued yet
    done = '0;
    check_outputs(done);
    for (i = 0; i < n_vectors; i++)
      apply_op(vectors[i]);
    for (i = 0; i < N_RANDOM; i++)
      apply_op(random_vector());
    opcode = OP_CLR;
    waited = 0;
    while (pending.size() > 0 && waited < FLUSH_TIMEOUT)
    begin
      done = pending.pop_front();
      check_outputs(done);
      waited++;
      @(negedge clk);
    end
    if (pending.size() > 0)
    begin
      n_errors++;
      $display("operations still in flight after %0d cycles of draining", FLUSH_TIMEOUT);
    end
    $display("checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  initial
  begin : watchdog
    int n;
    for (n = 0; n < MAX_CYCLES; n++)
      @(posedge clk);
    $display("timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  `include "tb_alu_model.svh"

endmodule

`default_nettype wire

//--- rtl/alu_core.sv
/* alu core top level
   opcode controller, execute stage and writeback joined on plain ports */
`timescale 1ns/1ps
`default_nettype none

module alu_core
  import alu_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic [OP_W-1:0]   opcode,
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  output logic [DATA_W-1:0] result,
  output logic              flag_z,
  output logic              flag_v,
  output logic              flag_c
);

  alu_exec_t  exec_data;
  alu_flags_t flags;

  alu_ctrl_if ctrl_bus ();

  alu_controller u_controller (
    .clk    (clk),
    .reset  (reset),
    .opcode (alu_op_e'(opcode)),
    .ctrl   (ctrl_bus.ctrl)
  );

  alu_exec u_exec (
    .clk      (clk),
    .reset    (reset),
    .a        (a),
    .b        (b),
    .ctrl     (ctrl_bus.exec),
    .exec_out (exec_data)
  );

  alu_writeback u_writeback (
    .clk     (clk),
    .reset   (reset),
    .ctrl    (ctrl_bus.wb),
    .exec_in (exec_data),
    .result  (result),
    .flags   (flags)
  );

  assign flag_z = flags.z;
  assign flag_v = flags.v;
  assign flag_c = flags.c;

endmodule

`default_nettype wire

//--- rtl/alu_writeback.sv
/* alu writeback
   result register and Z/V/C flags, loaded or cleared by the decoded levels */
`timescale 1ns/1ps
`default_nettype none

module alu_writeback
  import alu_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  alu_ctrl_if.wb            ctrl,
  input  alu_exec_t         exec_in,
  output logic [DATA_W-1:0] result,
  output alu_flags_t        flags
);

  alu_flags_t next_flags;

  assign next_flags.z = (exec_in.value == '0);
  assign next_flags.v = exec_in.v;
  assign next_flags.c = exec_in.c;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      result <= '0;
      flags  <= '0;
    end
    else if (ctrl.clr)
    begin
      result <= '0;
      flags  <= '0;
    end
    else
    begin
      if (ctrl.load_inputs)
        flags <= next_flags;
      // compare loads flags only
      if (ctrl.load_outputs)
        result <= exec_in.value;
    end
  end

endmodule

`default_nettype wire

//--- rtl/alu_exec.sv
/* alu execute stage
   registers the operands and forms the value, carry and overflow of each operation */
`timescale 1ns/1ps
`default_nettype none

module alu_exec
  import alu_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  alu_ctrl_if.exec          ctrl,
  output alu_exec_t         exec_out
);

  logic [DATA_W-1:0]   a_q;
  logic [DATA_W-1:0]   b_q;

  logic [DATA_W-1:0]   add_x;
  logic [DATA_W-1:0]   add_y;
  logic                do_sub;
  logic [DATA_W:0]     arith;
  logic                y_sign;
  logic                arith_v;
  logic                is_arith;

  logic [2*DATA_W-1:0] product;

  logic [DATA_W-1:0]   shift_value;
  logic                shift_out;
  logic                shift_ovf;

  // sampled on the same edge as the opcode
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      a_q <= '0;
      b_q <= '0;
    end
    else
    begin
      a_q <= a;
      b_q <= b;
    end
  end

  // one shared adder for add, sub, cmp, inc and dec
  always_comb
  begin
    add_x  = a_q;
    add_y  = b_q;
    do_sub = ctrl.op_sel[OP_SUB] | ctrl.op_sel[OP_CMP];
    if (ctrl.op_sel[OP_INC_A] | ctrl.op_sel[OP_DEC_A])
      add_y = DATA_W'(1);
    if (ctrl.op_sel[OP_INC_B] | ctrl.op_sel[OP_DEC_B])
    begin
      add_x = b_q;
      add_y = DATA_W'(1);
    end
    if (ctrl.op_sel[OP_DEC_A] | ctrl.op_sel[OP_DEC_B])
      do_sub = 1'b1;
  end

  // bit DATA_W is carry out for add and borrow for subtract
  assign arith   = do_sub ? {1'b0, add_x} - {1'b0, add_y}
                          : {1'b0, add_x} + {1'b0, add_y};
  assign y_sign  = do_sub ? ~add_y[DATA_W-1] : add_y[DATA_W-1];
  assign arith_v = (add_x[DATA_W-1] == y_sign) && (arith[DATA_W-1] != add_x[DATA_W-1]);

  assign is_arith = ctrl.op_sel[OP_ADD]   | ctrl.op_sel[OP_SUB]   | ctrl.op_sel[OP_CMP] |
                    ctrl.op_sel[OP_INC_A] | ctrl.op_sel[OP_INC_B] |
                    ctrl.op_sel[OP_DEC_A] | ctrl.op_sel[OP_DEC_B];

  assign product = a_q * b_q;

  alu_shifter u_shifter (
    .operand     (a_q),
    .shamt       (b_q[SHAMT_W-1:0]),
    .dir_left    (ctrl.op_sel[OP_ASL]),
    .value       (shift_value),
    .shifted_out (shift_out),
    .overflow    (shift_ovf)
  );

  // clear falls through to the zero default
  always_comb
  begin
    exec_out = '0;
    if (is_arith)
    begin
      exec_out.value = arith[DATA_W-1:0];
      exec_out.c     = arith[DATA_W];
      exec_out.v     = arith_v;
    end
    else if (ctrl.op_sel[OP_MUL])
    begin
      exec_out.value = product[DATA_W-1:0];
      exec_out.c     = |product[2*DATA_W-1:DATA_W];
    end
    else if (ctrl.op_sel[OP_AND])
      exec_out.value = a_q & b_q;
    else if (ctrl.op_sel[OP_OR])
      exec_out.value = a_q | b_q;
    else if (ctrl.op_sel[OP_XOR])
      exec_out.value = a_q ^ b_q;
    else if (ctrl.op_sel[OP_CPL_A])
      exec_out.value = ~a_q;
    else if (ctrl.op_sel[OP_CPL_B])
      exec_out.value = ~b_q;
    else if (ctrl.op_sel[OP_ASL] | ctrl.op_sel[OP_ASR])
    begin
      exec_out.value = shift_value;
      exec_out.c     = shift_out;
      exec_out.v     = shift_ovf;
    end
  end

endmodule

`default_nettype wire

//--- rtl/alu_controller.sv
/* alu opcode controller
   registers the opcode and decodes it into one-hot strobes and load levels */
`timescale 1ns/1ps
`default_nettype none

module alu_controller
  import alu_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  alu_op_e opcode,
  alu_ctrl_if.ctrl ctrl
);

  alu_op_e this_opcode;

  always_ff @(posedge clk)
  begin
    if (reset)
      this_opcode <= OP_CLR;
    else
      this_opcode <= opcode;
  end

  always_comb
  begin
    ctrl.op_sel = '0;
    ctrl.op_sel[this_opcode] = 1'b1;
  end

  // load levels per opcode
  always_comb
  begin
    ctrl.clr          = 1'b0;
    ctrl.load_inputs  = 1'b0;
    ctrl.load_outputs = 1'b0;

    case (this_opcode)
      OP_CLR:
      begin
        ctrl.clr = 1'b1;
      end
      OP_CMP:
      begin
        // loads the flags and keeps the result
        ctrl.load_inputs = 1'b1;
      end
      OP_ADD,
      OP_SUB,
      OP_INC_A,
      OP_INC_B,
      OP_DEC_A,
      OP_DEC_B,
      OP_MUL,
      OP_AND,
      OP_OR,
      OP_XOR,
      OP_CPL_A,
      OP_CPL_B,
      OP_ASL,
      OP_ASR:
      begin
        ctrl.load_inputs  = 1'b1;
        ctrl.load_outputs = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/alu_shifter.sv
/* arithmetic barrel shifter
   shifts left with zero fill or right with sign fill, reports the last bit out */
`timescale 1ns/1ps
`default_nettype none

module alu_shifter
  import alu_pkg::*;
(
  input  logic [DATA_W-1:0]  operand,
  input  logic [SHAMT_W-1:0] shamt,
  input  logic               dir_left,
  output logic [DATA_W-1:0]  value,
  output logic               shifted_out,
  output logic               overflow
);

  logic [DATA_W:0] left_ext;
  logic [DATA_W:0] right_ext;

  // one guard bit on each side catches the last bit shifted out
  assign left_ext  = {1'b0, operand} << shamt;
  assign right_ext = $signed({operand, 1'b0}) >>> shamt;

  always_comb
  begin
    if (dir_left)
    begin
      value       = left_ext[DATA_W-1:0];
      shifted_out = left_ext[DATA_W];
      overflow    = left_ext[DATA_W-1] != operand[DATA_W-1];
    end
    else
    begin
      value       = right_ext[DATA_W:1];
      shifted_out = right_ext[0];
      overflow    = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- rtl/alu_ctrl_if.sv
/* alu control bus
   decoded operation strobes and load levels from the controller to the datapath */
`timescale 1ns/1ps
`default_nettype none

interface alu_ctrl_if
  import alu_pkg::*;
();

  // one-hot on the alu_op_e index
  logic [N_OPS-1:0] op_sel;
  logic             load_inputs;
  logic             load_outputs;
  logic             clr;

  modport ctrl (
    output op_sel,
    output load_inputs,
    output load_outputs,
    output clr
  );

  modport exec (
    input op_sel
  );

  modport wb (
    input load_inputs,
    input load_outputs,
    input clr
  );

endinterface

`default_nettype wire

//--- rtl/alu_pkg.sv
/* alu package
   opcode encoding, widths and the structs passed between the ALU blocks */
`default_nettype none

package alu_pkg;

  localparam int DATA_W  = 8;
  localparam int OP_W    = 4;
  localparam int SHAMT_W = 3;
  localparam int N_OPS   = 16;

  // opcode numbering is also the bit index into the one-hot op_sel vector
  typedef enum logic [OP_W-1:0] {
    OP_CLR   = 4'd0,
    OP_ADD   = 4'd1,
    OP_SUB   = 4'd2,
    OP_CMP   = 4'd3,
    OP_INC_A = 4'd4,
    OP_INC_B = 4'd5,
    OP_DEC_A = 4'd6,
    OP_DEC_B = 4'd7,
    OP_MUL   = 4'd8,
    OP_AND   = 4'd9,
    OP_OR    = 4'd10,
    OP_XOR   = 4'd11,
    OP_CPL_A = 4'd12,
    OP_CPL_B = 4'd13,
    OP_ASL   = 4'd14,
    OP_ASR   = 4'd15
  } alu_op_e;

  typedef struct packed {
    logic z;
    logic v;
    logic c;
  } alu_flags_t;

  // value plus the flag bits formed alongside it
  typedef struct packed {
    logic [DATA_W-1:0] value;
    logic              v;
    logic              c;
  } alu_exec_t;

endpackage

`default_nettype wire
